// File: adc_rx_top.f
common/adc_rx_pkg.sv
common/lane_word_if.sv
deser/adc_lane_deser.sv
src/frame_align_mon.sv
src/adc_ctrl_regs.sv
src/adc_sample_out.sv
src/adc_rx_top.sv
sim/adc_rx_checker.sv
sim/tb_adc_rx.sv

// File: common/adc_rx_pkg.sv
package adc_rx_pkg;

  // Lane geometry
  localparam int NUM_LANES      = 4;
  localparam int WORD_W         = 10;
  localparam int PAIRS_PER_WORD = 5;
  localparam int HIST_W         = 2 * WORD_W;
  localparam int DOUT_W         = NUM_LANES * WORD_W;

  // Bitslip offset runs 0 to WORD_W-1
  localparam int OFFSET_W   = 4;
  localparam int MAX_OFFSET = WORD_W - 1;

  // Phase count over the bit pairs of one word
  localparam int PHASE_W    = 3;
  localparam int PHASE_LAST = PAIRS_PER_WORD - 1;

  // Frame monitor
  localparam int ERR_CNT_W = 16;
  localparam int ALIGN_RUN = 4;
  localparam int RUN_CNT_W = $clog2(ALIGN_RUN + 1);

  // Register bus
  localparam int WB_ADR_W = 32;
  localparam int WB_DAT_W = 32;

  typedef logic [WORD_W-1:0]    sample_word_t;
  typedef logic [NUM_LANES:0]   lane_mask_t;
  typedef logic [ERR_CNT_W-1:0] err_cnt_t;
  typedef logic [WB_DAT_W-1:0]  reg_data_t;
  typedef logic [WB_ADR_W-1:0]  wb_addr_t;
  typedef logic [HIST_W-1:0]    bit_hist_t;
  typedef logic [OFFSET_W-1:0]  slip_off_t;
  typedef logic [PHASE_W-1:0]   pair_phase_t;
  typedef logic [RUN_CNT_W-1:0] run_cnt_t;
  typedef logic [DOUT_W-1:0]    sample_bus_t;

  // Five ones then five zeros, MSB first
  localparam sample_word_t FRAME_PATTERN = 10'b11111_00000;

  // Byte addresses
  localparam wb_addr_t REG_BITSLIP  = 32'h0000_0000;
  localparam wb_addr_t REG_ERR_CNT  = 32'h0000_0004;
  localparam wb_addr_t REG_STATUS   = 32'h0000_0008;
  localparam wb_addr_t REG_WORD_CNT = 32'h0000_000C;

  // Status register bits
  localparam int STAT_ALIGNED_BIT = 0;
  localparam int STAT_RUNNING_BIT = 1;

endpackage

// File: common/lane_word_if.sv
`timescale 1ns/1ps

interface lane_word_if;

  // One strobe per finished word, all lanes together
  logic                                                  word_stb;
  adc_rx_pkg::sample_word_t [adc_rx_pkg::NUM_LANES-1:0] data_words;
  adc_rx_pkg::sample_word_t                              frame_word;
  // Frame lane in the top bit
  adc_rx_pkg::lane_mask_t                                bitslip;

  modport deser (
    output word_stb,
    output data_words,
    output frame_word,
    input  bitslip
  );

  modport mon (
    input word_stb,
    input frame_word
  );

  modport sink (
    input word_stb,
    input data_words
  );

  modport ctrl (
    output bitslip
  );

endinterface

// File: deser/adc_lane_deser.sv
`timescale 1ns/1ps

module adc_lane_deser (
  input  logic                             fclk_int,
  input  logic                             rst,
  input  logic [adc_rx_pkg::NUM_LANES-1:0] din_rise_i,
  input  logic [adc_rx_pkg::NUM_LANES-1:0] din_fall_i,
  input  logic                             frame_rise_i,
  input  logic                             frame_fall_i,
  lane_word_if.deser                       words
);

  // Data lanes plus the frame lane
  localparam int N_CH = adc_rx_pkg::NUM_LANES + 1;

  logic [N_CH-1:0]                                     rise_bits;
  logic [N_CH-1:0]                                     fall_bits;
  adc_rx_pkg::pair_phase_t                             phase;
  logic                                                word_due;
  logic                                                word_stb_q;
  adc_rx_pkg::bit_hist_t                               hist     [N_CH];
  adc_rx_pkg::bit_hist_t                               hist_nxt [N_CH];
  adc_rx_pkg::slip_off_t                               offset     [N_CH];
  adc_rx_pkg::slip_off_t                               offset_nxt [N_CH];
  adc_rx_pkg::sample_word_t                            word_sel [N_CH];
  adc_rx_pkg::sample_word_t [adc_rx_pkg::NUM_LANES-1:0] data_q;
  adc_rx_pkg::sample_word_t                            frame_q;

  assign rise_bits = {frame_rise_i, din_rise_i};
  assign fall_bits = {frame_fall_i, din_fall_i};

  // Last pair of the word arrives this cycle
  assign word_due = (phase == adc_rx_pkg::PHASE_LAST);

  always_comb begin
    for (int ch = 0; ch < N_CH; ch++) begin
      // Rise bit is older than fall bit
      hist_nxt[ch] = {hist[ch][adc_rx_pkg::HIST_W-3:0], rise_bits[ch], fall_bits[ch]};
      if (!words.bitslip[ch]) begin
        offset_nxt[ch] = offset[ch];
      end else if (offset[ch] == adc_rx_pkg::MAX_OFFSET) begin
        offset_nxt[ch] = '0;
      end else begin
        offset_nxt[ch] = offset[ch] + 1'b1;
      end
      // Skip the newest offset bits, older bits end up on top
      word_sel[ch] = hist_nxt[ch][offset_nxt[ch] +: adc_rx_pkg::WORD_W];
    end
  end

  always_ff @(posedge fclk_int) begin
    if (rst) begin
      phase      <= '0;
      word_stb_q <= 1'b0;
      for (int ch = 0; ch < N_CH; ch++) begin
        offset[ch] <= '0;
      end
    end else begin
      phase      <= word_due ? '0 : phase + 1'b1;
      word_stb_q <= word_due;
      for (int ch = 0; ch < N_CH; ch++) begin
        offset[ch] <= offset_nxt[ch];
      end
    end
  end

  always_ff @(posedge fclk_int) begin
    for (int ch = 0; ch < N_CH; ch++) begin
      hist[ch] <= hist_nxt[ch];
    end
    if (word_due) begin
      for (int ln = 0; ln < adc_rx_pkg::NUM_LANES; ln++) begin
        data_q[ln] <= word_sel[ln];
      end
      frame_q <= word_sel[adc_rx_pkg::NUM_LANES];
    end
  end

  assign words.word_stb   = word_stb_q;
  assign words.data_words = data_q;
  assign words.frame_word = frame_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log
LOG=sim.log
verilator --binary --timing -Wno-fatal --top-module tb_adc_rx -f adc_rx_top.f -Mdir obj_dir \
  && ./obj_dir/Vtb_adc_rx > "$LOG" 2>&1 \
  || { echo "Verilator build or run failed"; exit 1; }
cat "$LOG"
grep -q "Simulation FAILED" "$LOG" && exit 1 || exit 0

// File: sim/adc_rx_checker.sv
`timescale 1ns/1ps

module adc_rx_checker (
  input  logic                             fclk_int,
  input  logic                             rst,
  input  logic                             sync_i,
  input  logic [adc_rx_pkg::NUM_LANES-1:0] din_rise_i,
  input  logic [adc_rx_pkg::NUM_LANES-1:0] din_fall_i,
  input  logic                             frame_rise_i,
  input  logic                             frame_fall_i,
  input  logic                             wb_cyc_i,
  input  logic                             wb_stb_i,
  input  logic                             wb_we_i,
  input  adc_rx_pkg::wb_addr_t             wb_adr_i,
  input  adc_rx_pkg::reg_data_t            wb_dat_i,
  input  adc_rx_pkg::sample_bus_t          dout_i,
  input  logic                             dout_valid_i,
  input  logic                             sync_out_i,
  input  logic                             aligned_i,
  input  adc_rx_pkg::reg_data_t            wb_rdat_i,
  input  logic                             wb_ack_i,
  output int                               check_cnt_o,
  output int                               error_cnt_o
);

  localparam int N_CH = adc_rx_pkg::NUM_LANES + 1;

  logic [2*adc_rx_pkg::WORD_W-1:0] hist [N_CH];
  adc_rx_pkg::sample_word_t        words [N_CH];
  int                              off [N_CH];
  int                              phase;
  int                              run_len;
  logic                            stb;
  adc_rx_pkg::err_cnt_t            err_exp;
  logic [2:0]                      sync_sh;
  logic                            running;
  logic                            first_pending;
  logic                            valid_exp;
  logic                            sync_exp;
  adc_rx_pkg::sample_bus_t         dout_exp;
  logic                            ack_exp;
  logic                            pend_we;
  adc_rx_pkg::wb_addr_t            pend_adr;
  adc_rx_pkg::reg_data_t           pend_dat;
  adc_rx_pkg::reg_data_t           rdata_exp;
  adc_rx_pkg::reg_data_t           word_cnt;
  logic                            model_live = 1'b0;
  int                              checks = 0;
  int                              errors = 0;

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %0h actual %0h at %0t", name, exp, act, $time);
    end
  endtask

  // Register contents as the bus should see them at request time
  function automatic adc_rx_pkg::reg_data_t expected_read(input adc_rx_pkg::wb_addr_t adr);
    case (adr)
      adc_rx_pkg::REG_ERR_CNT:  return 32'(err_exp);
      adc_rx_pkg::REG_STATUS:   return {30'b0, running, run_len == adc_rx_pkg::ALIGN_RUN};
      adc_rx_pkg::REG_WORD_CNT: return word_cnt;
      default:                  return '0;
    endcase
  endfunction

  always @(posedge fclk_int) begin : model_step
    logic                   req;
    logic                   clr;
    logic                   stb_now;
    adc_rx_pkg::lane_mask_t slip;
    // Rise bit first, the newest bit sits at the bottom
    for (int ch = 0; ch < N_CH; ch++) begin
      if (ch < adc_rx_pkg::NUM_LANES) begin
        hist[ch] = {hist[ch][2*adc_rx_pkg::WORD_W-3:0], din_rise_i[ch], din_fall_i[ch]};
      end else begin
        hist[ch] = {hist[ch][2*adc_rx_pkg::WORD_W-3:0], frame_rise_i, frame_fall_i};
      end
    end
    if (rst) begin
      model_live    = 1'b1;
      phase         = 0;
      stb           = 1'b0;
      run_len       = 0;
      err_exp       = '0;
      sync_sh       = '0;
      running       = 1'b0;
      first_pending = 1'b0;
      valid_exp     = 1'b0;
      sync_exp      = 1'b0;
      ack_exp       = 1'b0;
      pend_we       = 1'b0;
      word_cnt      = '0;
      for (int ch = 0; ch < N_CH; ch++) begin
        off[ch] = 0;
      end
    end else if (model_live) begin
      compare("wb_ack_o", ack_exp, wb_ack_i);
      if (ack_exp && !pend_we) begin
        compare("wb_dat_o", rdata_exp, wb_rdat_i);
      end
      compare("dout_valid_o", valid_exp, dout_valid_i);
      compare("sync_o", sync_exp, sync_out_i);
      compare("aligned_o", run_len == adc_rx_pkg::ALIGN_RUN, aligned_i);
      if (valid_exp) begin
        compare("dout_o", dout_exp, dout_i);
      end

      // Write side effects land in the ack cycle
      stb_now = stb;
      slip    = '0;
      clr     = ack_exp && pend_we && (pend_adr == adc_rx_pkg::REG_ERR_CNT);
      if (ack_exp && pend_we && (pend_adr == adc_rx_pkg::REG_BITSLIP)) begin
        slip = pend_dat[adc_rx_pkg::NUM_LANES:0];
      end
      req = wb_cyc_i && wb_stb_i && !ack_exp;
      if (req) begin
        pend_we   = wb_we_i;
        pend_adr  = wb_adr_i;
        pend_dat  = wb_dat_i;
        rdata_exp = expected_read(wb_adr_i);
      end
      ack_exp = req;

      // Frame monitor
      if (clr) begin
        err_exp = '0;
      end else if (stb_now && words[N_CH-1] != adc_rx_pkg::FRAME_PATTERN && err_exp != '1) begin
        err_exp = err_exp + 1'b1;
      end
      if (stb_now) begin
        if (words[N_CH-1] != adc_rx_pkg::FRAME_PATTERN) begin
          run_len = 0;
        end else if (run_len < adc_rx_pkg::ALIGN_RUN) begin
          run_len++;
        end
      end

      // Output stage
      valid_exp = running && stb_now;
      sync_exp  = running && first_pending && stb_now;
      if (running && stb_now) begin
        first_pending = 1'b0;
        for (int ln = 0; ln < adc_rx_pkg::NUM_LANES; ln++) begin
          dout_exp[ln*adc_rx_pkg::WORD_W +: adc_rx_pkg::WORD_W] = words[ln];
        end
      end
      if (!running && sync_sh[1] && !sync_sh[2]) begin
        running       = 1'b1;
        first_pending = 1'b1;
      end
      sync_sh = {sync_sh[1:0], sync_i};
      if (stb_now) begin
        word_cnt = word_cnt + 1;
      end

      // Deserializer with per-lane offsets
      for (int ch = 0; ch < N_CH; ch++) begin
        if (slip[ch]) begin
          off[ch] = (off[ch] == adc_rx_pkg::WORD_W - 1) ? 0 : off[ch] + 1;
        end
      end
      stb = (phase == adc_rx_pkg::PAIRS_PER_WORD - 1);
      if (stb) begin
        for (int ch = 0; ch < N_CH; ch++) begin
          for (int b = 0; b < adc_rx_pkg::WORD_W; b++) begin
            words[ch][b] = hist[ch][off[ch] + b];
          end
        end
      end
      phase = stb ? 0 : phase + 1;
    end
  end

  assign check_cnt_o = checks;
  assign error_cnt_o = errors;

endmodule

// File: sim/tb_adc_rx.sv
`timescale 1ns/1ps

module tb_adc_rx;

  localparam int          CLK_HALF    = 10;
  localparam logic [31:0] SEED        = 32'hab3ee4ea;
  // Upper bound on the words that the whole sequence spans
  localparam int          TEST_WORDS  = 140;
  localparam int          WDOG_CYCLES = TEST_WORDS * adc_rx_pkg::PAIRS_PER_WORD + 200;

  logic                             fclk_int = 1'b0;
  logic                             rst;
  logic                             sync_i;
  logic [adc_rx_pkg::NUM_LANES-1:0] din_rise_i = '0;
  logic [adc_rx_pkg::NUM_LANES-1:0] din_fall_i = '0;
  logic                             frame_rise_i = 1'b0;
  logic                             frame_fall_i = 1'b0;
  logic                             wb_cyc_i;
  logic                             wb_stb_i;
  logic                             wb_we_i;
  adc_rx_pkg::wb_addr_t             wb_adr_i;
  adc_rx_pkg::reg_data_t            wb_dat_i;
  adc_rx_pkg::sample_bus_t          dout_o;
  logic                             dout_valid_o;
  logic                             sync_o;
  logic                             aligned_o;
  adc_rx_pkg::reg_data_t            wb_dat_o;
  logic                             wb_ack_o;
  int                               chk_checks;
  int                               chk_errors;
  int                               tb_errors = 0;
  int                               drv_phase = 0;
  int                               corrupt_req = 0;
  int                               corrupt_done = 0;
  logic [31:0]                      data_rng = SEED;
  logic [31:0]                      slip_rng;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  always #CLK_HALF fclk_int = ~fclk_int;

  // Random data lanes, frame lane repeats its pattern from phase 0
  always @(posedge fclk_int) begin
    int   ph;
    logic flip;
    ph   = rst ? 0 : drv_phase;
    flip = 1'b0;
    if (ph == 0 && corrupt_done < corrupt_req) begin
      flip = 1'b1;
      corrupt_done++;
    end
    data_rng = xorshift32(data_rng);
    din_rise_i   <= data_rng[3:0];
    din_fall_i   <= data_rng[11:8];
    frame_rise_i <= adc_rx_pkg::FRAME_PATTERN[adc_rx_pkg::WORD_W - 1 - 2 * ph] ^ flip;
    frame_fall_i <= adc_rx_pkg::FRAME_PATTERN[adc_rx_pkg::WORD_W - 2 - 2 * ph];
    drv_phase = (ph == adc_rx_pkg::PAIRS_PER_WORD - 1) ? 0 : ph + 1;
  end

  task automatic bus_access(input logic we, input adc_rx_pkg::wb_addr_t adr,
                            input adc_rx_pkg::reg_data_t dat);
    int waited;
    @(posedge fclk_int);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    waited = 0;
    do begin
      @(posedge fclk_int);
      waited++;
    end while (!wb_ack_o && waited < 8);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    if (!wb_ack_o) begin
      tb_errors++;
      $display("Register access at address %0h was never acknowledged", adr);
    end
  endtask

  task automatic write_reg(input adc_rx_pkg::wb_addr_t adr, input adc_rx_pkg::reg_data_t dat);
    bus_access(1'b1, adr, dat);
  endtask

  task automatic read_reg(input adc_rx_pkg::wb_addr_t adr);
    bus_access(1'b0, adr, '0);
  endtask

  task automatic wait_samples(input int n);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    while (seen < n && cycles < n * adc_rx_pkg::PAIRS_PER_WORD + 20) begin
      @(posedge fclk_int);
      cycles++;
      if (dout_valid_o) seen++;
    end
    if (seen < n) begin
      tb_errors++;
      $display("Expected %0d output samples but only %0d arrived", n, seen);
    end
  endtask

  task automatic await_alignment();
    int cycles;
    cycles = 0;
    do begin
      @(posedge fclk_int);
      cycles++;
    end while (!aligned_o && cycles < 20 * adc_rx_pkg::PAIRS_PER_WORD);
    if (!aligned_o) begin
      tb_errors++;
      $display("Frame lane never reached alignment");
    end
  endtask

  adc_rx_top dut (.*);

  adc_rx_checker u_check (
    .fclk_int     (fclk_int),
    .rst          (rst),
    .sync_i       (sync_i),
    .din_rise_i   (din_rise_i),
    .din_fall_i   (din_fall_i),
    .frame_rise_i (frame_rise_i),
    .frame_fall_i (frame_fall_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .dout_i       (dout_o),
    .dout_valid_i (dout_valid_o),
    .sync_out_i   (sync_o),
    .aligned_i    (aligned_o),
    .wb_rdat_i    (wb_dat_o),
    .wb_ack_i     (wb_ack_o),
    .check_cnt_o  (chk_checks),
    .error_cnt_o  (chk_errors)
  );

  initial begin
    repeat (WDOG_CYCLES) @(posedge fclk_int);
    $display("Timeout after %0d cycles, test sequence did not complete", WDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    rst      <= 1'b1;
    sync_i   <= 1'b0;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    wb_adr_i <= '0;
    wb_dat_i <= '0;
    slip_rng = xorshift32(SEED);
    repeat (10) @(posedge fclk_int);
    rst <= 1'b0;

    // Before sync, no samples leave the DUT
    await_alignment();
    read_reg(adc_rx_pkg::REG_STATUS);
    read_reg(adc_rx_pkg::REG_WORD_CNT);
    read_reg(adc_rx_pkg::REG_BITSLIP);
    read_reg(32'h0000_0010);
    read_reg(32'h0000_0006);

    @(posedge fclk_int);
    sync_i <= 1'b1;
    wait_samples(6);
    read_reg(adc_rx_pkg::REG_STATUS);
    read_reg(adc_rx_pkg::REG_WORD_CNT);
    wait_samples(4);
    read_reg(adc_rx_pkg::REG_WORD_CNT);

    // Second sync edge while already running
    @(posedge fclk_int);
    sync_i <= 1'b0;
    wait_samples(1);
    sync_i <= 1'b1;
    wait_samples(3);

    // Three corrupted frame words
    write_reg(adc_rx_pkg::REG_ERR_CNT, '0);
    @(posedge fclk_int);
    corrupt_req <= corrupt_req + 3;
    wait_samples(5);
    read_reg(adc_rx_pkg::REG_ERR_CNT);
    read_reg(adc_rx_pkg::REG_STATUS);
    write_reg(adc_rx_pkg::REG_ERR_CNT, '0);
    read_reg(adc_rx_pkg::REG_ERR_CNT);
    await_alignment();
    read_reg(adc_rx_pkg::REG_STATUS);

    repeat (12) begin
      slip_rng = xorshift32(slip_rng);
      write_reg(adc_rx_pkg::REG_BITSLIP, {28'b0, slip_rng[3:0]});
      wait_samples(1);
    end
    // Ten slips on every lane bring the offsets full circle
    repeat (10) write_reg(adc_rx_pkg::REG_BITSLIP, 32'h1F);
    await_alignment();
    wait_samples(3);
    read_reg(adc_rx_pkg::REG_ERR_CNT);
    read_reg(adc_rx_pkg::REG_WORD_CNT);
    wait_samples(2);

    $display("Checks: %0d, checker errors: %0d, testbench errors: %0d",
             chk_checks, chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: src/adc_ctrl_regs.sv
`timescale 1ns/1ps

module adc_ctrl_regs (
  input  logic                  fclk_int,
  input  logic                  rst,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  adc_rx_pkg::wb_addr_t  wb_adr_i,
  input  adc_rx_pkg::reg_data_t wb_dat_i,
  output adc_rx_pkg::reg_data_t wb_dat_o,
  output logic                  wb_ack_o,
  lane_word_if.ctrl             words,
  input  adc_rx_pkg::err_cnt_t  err_cnt_i,
  input  logic                  aligned_i,
  input  logic                  running_i,
  output logic                  err_clr_o,
  input  logic                  word_stb_i
);

  logic                   ack_q;
  logic                   req_new;
  logic                   wr_new;
  logic                   clr_q;
  adc_rx_pkg::lane_mask_t slip_q;
  adc_rx_pkg::reg_data_t  rd_mux;
  adc_rx_pkg::reg_data_t  rd_q;
  adc_rx_pkg::reg_data_t  word_cnt;

  // Master holds the request through the ack cycle, take it once
  assign req_new = wb_cyc_i & wb_stb_i & ~ack_q;
  assign wr_new  = req_new & wb_we_i;

  always_comb begin
    rd_mux = '0;
    case (wb_adr_i)
      adc_rx_pkg::REG_ERR_CNT: begin
        rd_mux = adc_rx_pkg::reg_data_t'(err_cnt_i);
      end
      adc_rx_pkg::REG_STATUS: begin
        rd_mux[adc_rx_pkg::STAT_ALIGNED_BIT] = aligned_i;
        rd_mux[adc_rx_pkg::STAT_RUNNING_BIT] = running_i;
      end
      adc_rx_pkg::REG_WORD_CNT: begin
        rd_mux = word_cnt;
      end
      // Bitslip is write only
      default: begin
        rd_mux = '0;
      end
    endcase
  end

  always_ff @(posedge fclk_int) begin
    if (rst) begin
      ack_q    <= 1'b0;
      slip_q   <= '0;
      clr_q    <= 1'b0;
      word_cnt <= '0;
    end else begin
      ack_q <= req_new;
      // Write side effects are single pulses in the ack cycle
      if (wr_new && (wb_adr_i == adc_rx_pkg::REG_BITSLIP)) begin
        slip_q <= wb_dat_i[adc_rx_pkg::NUM_LANES:0];
      end else begin
        slip_q <= '0;
      end
      clr_q <= wr_new && (wb_adr_i == adc_rx_pkg::REG_ERR_CNT);
      if (word_stb_i) begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  // Read data lines up with the ack
  always_ff @(posedge fclk_int) begin
    if (req_new) begin
      rd_q <= rd_mux;
    end
  end

  assign wb_ack_o      = ack_q;
  assign wb_dat_o      = rd_q;
  assign err_clr_o     = clr_q;
  assign words.bitslip = slip_q;

endmodule

// File: src/adc_rx_top.sv
`timescale 1ns/1ps

module adc_rx_top (
  input  logic                                fclk_int,
  input  logic                                rst,
  input  logic                                sync_i,
  input  logic [adc_rx_pkg::NUM_LANES-1:0]    din_rise_i,
  input  logic [adc_rx_pkg::NUM_LANES-1:0]    din_fall_i,
  input  logic                                frame_rise_i,
  input  logic                                frame_fall_i,
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  input  logic                                wb_we_i,
  input  adc_rx_pkg::wb_addr_t                wb_adr_i,
  input  adc_rx_pkg::reg_data_t               wb_dat_i,
  output adc_rx_pkg::sample_bus_t             dout_o,
  output logic                                dout_valid_o,
  output logic                                sync_o,
  output logic                                aligned_o,
  output adc_rx_pkg::reg_data_t               wb_dat_o,
  output logic                                wb_ack_o
);

  adc_rx_pkg::err_cnt_t err_cnt;
  logic                 aligned;
  logic                 running;
  logic                 err_clr;

  lane_word_if lane_words ();

  adc_lane_deser u_deser (
    .fclk_int     (fclk_int),
    .rst          (rst),
    .din_rise_i   (din_rise_i),
    .din_fall_i   (din_fall_i),
    .frame_rise_i (frame_rise_i),
    .frame_fall_i (frame_fall_i),
    .words        (lane_words.deser)
  );

  frame_align_mon u_frame_mon (
    .fclk_int  (fclk_int),
    .rst       (rst),
    .words     (lane_words.mon),
    .err_clr_i (err_clr),
    .err_cnt_o (err_cnt),
    .aligned_o (aligned)
  );

  adc_ctrl_regs u_regs (
    .fclk_int   (fclk_int),
    .rst        (rst),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .words      (lane_words.ctrl),
    .err_cnt_i  (err_cnt),
    .aligned_i  (aligned),
    .running_i  (running),
    .err_clr_o  (err_clr),
    .word_stb_i (lane_words.word_stb)
  );

  adc_sample_out u_sample_out (
    .fclk_int     (fclk_int),
    .rst          (rst),
    .sync_i       (sync_i),
    .words        (lane_words.sink),
    .dout_o       (dout_o),
    .dout_valid_o (dout_valid_o),
    .sync_o       (sync_o),
    .running_o    (running)
  );

  assign aligned_o = aligned;

endmodule

// File: src/adc_sample_out.sv
`timescale 1ns/1ps

module adc_sample_out (
  input  logic                    fclk_int,
  input  logic                    rst,
  input  logic                    sync_i,
  lane_word_if.sink               words,
  output adc_rx_pkg::sample_bus_t dout_o,
  output logic                    dout_valid_o,
  output logic                    sync_o,
  output logic                    running_o
);

  typedef enum logic [1:0] {
    RUN_IDLE,
    RUN_FIRST,
    RUN_ACTIVE
  } run_state_t;

  run_state_t              state;
  logic                    sync_q1;
  logic                    sync_q2;
  logic                    sync_q3;
  logic                    sync_rise;
  logic                    running;
  logic                    valid_q;
  logic                    sync_out_q;
  adc_rx_pkg::sample_bus_t dout_q;

  // Two-flop synchronizer, third flop for the edge
  always_ff @(posedge fclk_int) begin
    if (rst) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
      sync_q3 <= 1'b0;
    end else begin
      sync_q1 <= sync_i;
      sync_q2 <= sync_q1;
      sync_q3 <= sync_q2;
    end
  end

  assign sync_rise = sync_q2 & ~sync_q3;
  assign running   = (state != RUN_IDLE);

  always_ff @(posedge fclk_int) begin
    if (rst) begin
      state      <= RUN_IDLE;
      valid_q    <= 1'b0;
      sync_out_q <= 1'b0;
    end else begin
      valid_q    <= running & words.word_stb;
      // First sample after the sync edge gets flagged
      sync_out_q <= (state == RUN_FIRST) & words.word_stb;
      case (state)
        RUN_IDLE:   if (sync_rise) state <= RUN_FIRST;
        RUN_FIRST:  if (words.word_stb) state <= RUN_ACTIVE;
        RUN_ACTIVE: state <= RUN_ACTIVE;
        default:    state <= RUN_IDLE;
      endcase
    end
  end

  // Lane 0 lands in the low bits
  always_ff @(posedge fclk_int) begin
    if (running && words.word_stb) begin
      dout_q <= words.data_words;
    end
  end

  assign dout_o       = dout_q;
  assign dout_valid_o = valid_q;
  assign sync_o       = sync_out_q;
  assign running_o    = running;

endmodule

// File: src/frame_align_mon.sv
`timescale 1ns/1ps

module frame_align_mon (
  input  logic                 fclk_int,
  input  logic                 rst,
  lane_word_if.mon             words,
  input  logic                 err_clr_i,
  output adc_rx_pkg::err_cnt_t err_cnt_o,
  output logic                 aligned_o
);

  adc_rx_pkg::err_cnt_t err_cnt;
  adc_rx_pkg::run_cnt_t run_cnt;
  logic                 frame_ok;
  logic                 err_full;
  logic                 run_full;

  assign frame_ok = (words.frame_word == adc_rx_pkg::FRAME_PATTERN);
  // Counter sticks at all ones
  assign err_full = &err_cnt;
  assign run_full = (run_cnt == adc_rx_pkg::ALIGN_RUN);

  // Mismatch counter, clear wins over a count
  always_ff @(posedge fclk_int) begin
    if (rst) begin
      err_cnt <= '0;
    end else if (err_clr_i) begin
      err_cnt <= '0;
    end else if (words.word_stb && !frame_ok && !err_full) begin
      err_cnt <= err_cnt + 1'b1;
    end
  end

  // Run of clean frame words
  always_ff @(posedge fclk_int) begin
    if (rst) begin
      run_cnt <= '0;
    end else if (words.word_stb) begin
      if (!frame_ok) begin
        run_cnt <= '0;
      end else if (!run_full) begin
        run_cnt <= run_cnt + 1'b1;
      end
    end
  end

  assign err_cnt_o = err_cnt;
  assign aligned_o = run_full;

endmodule
